// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - files:
      - hdl/soc_bus_pkg.sv
      - hdl/soc_map_pkg.sv
      - hdl/addr_decoder.sv
      - hdl/word_ram.sv
      - hdl/gpio_regs.sv
      - hdl/shared_ram_arbiter.sv
      - hdl/soc_fabric_top.sv
  - target: test
    files:
      - verification/soc_fabric_tb.sv

// ==== flist.f ====
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/addr_decoder.sv
hdl/word_ram.sv
hdl/gpio_regs.sv
hdl/shared_ram_arbiter.sv
hdl/soc_fabric_top.sv
verification/soc_fabric_tb.sv

// ==== hdl/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic    clk_rv,
    input  logic    rst_rv,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output logic    ram_stb,
    output logic    gpio_stb,
    output logic    z80_stb,
    input  wb_rsp_t ram_rsp,
    input  wb_rsp_t gpio_rsp,
    input  wb_rsp_t z80_rsp,
    output logic    bus_fault
);

    typedef enum logic [1:0] {ST_IDLE, ST_DECODE, ST_WAIT} state_e;

    state_e  state;
    region_e region_q;                  // Region of the cycle in flight
    wb_rsp_t tgt_rsp;                   // Response of the addressed target
    logic    done;

    function automatic region_e classify(input addr_t adr);
        if ((adr & RAM_MASK) == RAM_BASE) return REG_RAM;
        if ((adr & GPIO_MASK) == GPIO_BASE) return REG_GPIO;
        if ((adr & Z80_MASK) == Z80_BASE) return REG_Z80;
        return REG_NONE;
    endfunction

    // Cycle tracking ----------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state     <= ST_IDLE;
            region_q  <= REG_NONE;
            bus_fault <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (host_req.cyc && host_req.stb) begin
                        region_q <= classify(host_req.adr);
                        state    <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    if (region_q == REG_NONE)
                        bus_fault <= 1'b1;      // Sticky until reset
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One strobe pulse per cycle, only to the addressed target
    assign ram_stb  = (state == ST_DECODE) && (region_q == REG_RAM);
    assign gpio_stb = (state == ST_DECODE) && (region_q == REG_GPIO);
    assign z80_stb  = (state == ST_DECODE) && (region_q == REG_Z80);

    // Response path -----------------------
    always_comb begin
        case (region_q)
            REG_RAM:  tgt_rsp = ram_rsp;
            REG_GPIO: tgt_rsp = gpio_rsp;
            REG_Z80:  tgt_rsp = z80_rsp;
            default:  tgt_rsp = '{ack: 1'b0, err: 1'b1, dat: '0};  // Unmapped
        endcase
    end

    assign done     = (state == ST_WAIT) && (tgt_rsp.ack || tgt_rsp.err);
    assign host_rsp = (state == ST_WAIT) ? tgt_rsp : '0;

endmodule

// ==== hdl/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic       clk_rv,
    input  logic       rst_rv,
    input  wb_req_t    req,
    input  logic       stb,
    output wb_rsp_t    rsp,
    input  delay_t     delay_sel_det,
    input  logic       i2c_sda_in,
    output gpio_pins_t pins
);

    logic       ack_q;
    data_t      rdat_q;
    data_t      rd_mux;
    logic       sda_in_q;                   // SDA pin, sampled
    logic [3:0] reg_idx;
    logic       wr_en;

    assign reg_idx = req.adr[5:2];
    assign wr_en   = stb && req.we && (|req.sel);

    // Register writes ---------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            pins.led_r      <= 1'b0;
            pins.led_g      <= 1'b0;
            pins.led_b      <= 1'b0;
            pins.z80_rst    <= 1'b1;        // Z80 held until the host releases it
            pins.i2c_scl    <= 1'b1;
            pins.i2c_sda_oe <= 1'b0;        // SDA released
            pins.usb_rst_n  <= 1'b0;
            pins.delay_sel  <= delay_sel_det;
            ack_q           <= 1'b0;
        end else begin
            ack_q <= stb;
            if (wr_en) begin
                case (reg_idx)
                    GPIO_DELAY: pins.delay_sel <= req.dat[4:0];
                    GPIO_LED: begin
                        pins.led_r <= req.dat[0];
                        pins.led_g <= req.dat[1];
                        pins.led_b <= req.dat[2];
                    end
                    GPIO_Z80RST: pins.z80_rst    <= req.dat[0];
                    GPIO_SCL:    pins.i2c_scl    <= req.dat[0];
                    GPIO_SDA:    pins.i2c_sda_oe <= ~req.dat[0];   // Writing 0 pulls low
                    GPIO_USBRST: pins.usb_rst_n  <= req.dat[0];
                    default: ;
                endcase
            end
        end
    end

    // Read-back ---------------------------
    always_comb begin
        case (reg_idx)
            GPIO_DELAY:  rd_mux = {27'd0, pins.delay_sel};
            GPIO_LED:    rd_mux = {29'd0, pins.led_b, pins.led_g, pins.led_r};
            GPIO_Z80RST: rd_mux = {31'd0, pins.z80_rst};
            GPIO_SDA:    rd_mux = {31'd0, sda_in_q};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_rv) begin
        sda_in_q <= i2c_sda_in;
        if (stb)
            rdat_q <= rd_mux;
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

// ==== hdl/shared_ram_arbiter.sv ====
`timescale 1ns/1ps

module shared_ram_arbiter
    import soc_bus_pkg::*;
#(
    parameter int Z80_ADDR_W = 16
) (
    input  logic     clk_rv,
    input  logic     rst_rv,
    input  wb_req_t  host_req,
    input  logic     host_stb,
    output wb_rsp_t  host_rsp,
    input  z80_req_t z80_req,
    output z80_rsp_t z80_rsp,
    input  logic     z80_hold
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_Z80, ARB_HOST} state_e;

    // Access latched at the arbitration edge
    typedef struct packed {
        logic                  we;
        logic [Z80_ADDR_W-1:0] adr;
        byte_t                 dat;
    } grant_t;

    byte_t  mem [2**Z80_ADDR_W];
    state_e state;
    grant_t grant;
    byte_t  rd_q;
    logic   host_pend;                  // Host strobe seen, not yet served
    logic   host_want;
    logic   z80_go;
    logic   z80_ready_q;
    logic   host_ack_q;

    assign host_want = host_pend || host_stb;
    // Ready still high means the Z80 has not dropped mreq yet
    assign z80_go    = z80_req.mreq && !z80_hold && !z80_ready_q;

    // Arbitration -------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state       <= ARB_IDLE;
            host_pend   <= 1'b0;
            z80_ready_q <= 1'b0;
            host_ack_q  <= 1'b0;
        end else begin
            z80_ready_q <= 1'b0;
            host_ack_q  <= 1'b0;
            host_pend   <= host_want;
            case (state)
                ARB_IDLE: begin
                    if (z80_go) begin
                        state <= ARB_Z80;         // Z80 wins ties
                    end else if (host_want) begin
                        state     <= ARB_HOST;
                        host_pend <= 1'b0;
                    end
                end
                ARB_Z80: begin
                    z80_ready_q <= 1'b1;
                    state       <= ARB_IDLE;
                end
                ARB_HOST: begin
                    host_ack_q <= 1'b1;
                    state      <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Single RAM port -------------------
    always_ff @(posedge clk_rv) begin
        if (state == ARB_IDLE) begin
            if (z80_go)
                grant <= '{we: z80_req.we, adr: z80_req.adr[Z80_ADDR_W-1:0], dat: z80_req.dat};
            else if (host_want)
                grant <= '{we: host_req.we && host_req.sel[0],
                           adr: host_req.adr[Z80_ADDR_W+1:2],
                           dat: host_req.dat[7:0]};   // Low byte lane only
        end else begin
            rd_q <= mem[grant.adr];
            if (grant.we)
                mem[grant.adr] <= grant.dat;
        end
    end

    assign z80_rsp  = '{ready: z80_ready_q, dat: rd_q};
    assign host_rsp = '{ack: host_ack_q, err: 1'b0, dat: {24'd0, rd_q}};

endmodule

// ==== hdl/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // Vector types ------------------------
    typedef logic [31:0] addr_t;        // Host byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  sel_t;         // One bit per byte lane
    typedef logic [15:0] z80_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  delay_t;       // DDR delay tap select

    // Host bus, Wishbone classic ----------
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
        sel_t  sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        data_t dat;
    } wb_rsp_t;

    // Z80 memory port, wait style
    typedef struct packed {
        logic      mreq;
        logic      we;
        z80_addr_t adr;
        byte_t     dat;
    } z80_req_t;

    typedef struct packed {
        logic  ready;                   // Single cycle, read data valid with it
        byte_t dat;
    } z80_rsp_t;

    // Board pins driven by the GPIO block
    typedef struct packed {
        logic   led_r;
        logic   led_g;
        logic   led_b;
        logic   z80_rst;
        logic   i2c_scl;
        logic   i2c_sda_oe;             // High pulls SDA low
        logic   usb_rst_n;
        delay_t delay_sel;
    } gpio_pins_t;

endpackage

// ==== hdl/soc_fabric_top.sv ====
`timescale 1ns/1ps

module soc_fabric_top
    import soc_bus_pkg::*;
#(
    parameter int RAM_WORDS  = 2048,    // Internal RAM depth in words
    parameter int Z80_ADDR_W = 16       // Z80 RAM is 2**Z80_ADDR_W bytes
) (
    input  logic       clk_rv,
    input  logic       rst_rv,
    input  wb_req_t    host_req,
    output wb_rsp_t    host_rsp,
    input  z80_req_t   z80_req,
    output z80_rsp_t   z80_rsp,
    input  delay_t     delay_sel_det,
    input  logic       i2c_sda_in,
    output gpio_pins_t pins,
    output logic       bus_fault
);

    logic    ram_stb;
    logic    gpio_stb;
    logic    z80_stb;
    wb_rsp_t ram_rsp;
    wb_rsp_t gpio_rsp;
    wb_rsp_t z80_rsp_host;             // Host side of the Z80 RAM

    // Host decode -------------------------
    addr_decoder i_addr_decoder (
        .clk_rv    (clk_rv),
        .rst_rv    (rst_rv),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .ram_stb   (ram_stb),
        .gpio_stb  (gpio_stb),
        .z80_stb   (z80_stb),
        .ram_rsp   (ram_rsp),
        .gpio_rsp  (gpio_rsp),
        .z80_rsp   (z80_rsp_host),
        .bus_fault (bus_fault)
    );

    // Targets -----------------------------
    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_word_ram (
        .clk_rv (clk_rv),
        .req    (host_req),
        .stb    (ram_stb),
        .rsp    (ram_rsp)
    );

    gpio_regs i_gpio_regs (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .req           (host_req),
        .stb           (gpio_stb),
        .rsp           (gpio_rsp),
        .delay_sel_det (delay_sel_det),
        .i2c_sda_in    (i2c_sda_in),
        .pins          (pins)
    );

    // Z80 requests are held off while GPIO keeps the Z80 in reset
    shared_ram_arbiter #(
        .Z80_ADDR_W (Z80_ADDR_W)
    ) i_shared_ram_arbiter (
        .clk_rv   (clk_rv),
        .rst_rv   (rst_rv),
        .host_req (host_req),
        .host_stb (z80_stb),
        .host_rsp (z80_rsp_host),
        .z80_req  (z80_req),
        .z80_rsp  (z80_rsp),
        .z80_hold (pins.z80_rst)
    );

endmodule

// ==== hdl/soc_map_pkg.sv ====
package soc_map_pkg;

    // Host address regions ------------------
    typedef enum logic [1:0] {
        REG_NONE,                       // Unmapped, answered with err
        REG_RAM,
        REG_GPIO,
        REG_Z80
    } region_e;

    // Bases and masks -----------------------
    // A host address hits a region when (adr & MASK) == BASE

    // Internal RAM, the whole top 64 KB with echo
    localparam logic [31:0] RAM_BASE  = 32'hFFFF_0000;
    localparam logic [31:0] RAM_MASK  = 32'hFFFF_0000;

    localparam logic [31:0] GPIO_BASE = 32'h0300_0000;
    localparam logic [31:0] GPIO_MASK = 32'hFFFF_FF00;  // 256 bytes

    // Z80 RAM window, one byte per 32 bit word
    localparam logic [31:0] Z80_BASE  = 32'h0500_0000;
    localparam logic [31:0] Z80_MASK  = 32'hFFFC_0000;  // 256 KB

    // GPIO register word indices ------------
    // Selected by adr[5:2], indices 2 and 4 are holes
    localparam logic [3:0] GPIO_DELAY  = 4'd0;  // DDR delay select
    localparam logic [3:0] GPIO_LED    = 4'd1;  // b0 red, b1 green, b2 blue
    localparam logic [3:0] GPIO_Z80RST = 4'd3;  // Holds the Z80 in reset
    localparam logic [3:0] GPIO_SCL    = 4'd5;
    localparam logic [3:0] GPIO_SDA    = 4'd6;  // Write drives, read samples the pin
    localparam logic [3:0] GPIO_USBRST = 4'd7;  // Active low USB reset

endpackage

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps

module word_ram
    import soc_bus_pkg::*;
#(
    parameter int RAM_WORDS = 2048
) (
    input  logic    clk_rv,
    input  wb_req_t req,
    input  logic    stb,
    output wb_rsp_t rsp
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    data_t             mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;            // Higher address bits ignored so the range echoes
    logic              ack_q;
    data_t             rdat_q;

    assign idx = req.adr[IDX_W+1:2];

    always_ff @(posedge clk_rv) begin
        if (stb) begin
            for (int b = 0; b < 4; b++) begin
                if (req.we && req.sel[b])
                    mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
            end
            rdat_q <= mem[idx];         // Old word on a write
        end
    end

    // Ack one cycle after the strobe
    always_ff @(posedge clk_rv) begin
        ack_q <= stb;
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

// ==== verification/soc_fabric_tb.sv ====
`timescale 1ns/1ps

module soc_fabric_tb
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int     RAM_WORDS   = 2048;     // Matches the DUT default
    localparam int     BUS_TIMEOUT = 50;       // Cycles
    localparam int     Z80_TIMEOUT = 40;
    localparam delay_t DELAY_STRAP = 5'h13;

    logic       clk_rv;
    logic       rst_rv;
    wb_req_t    host_req;
    wb_rsp_t    host_rsp;
    z80_req_t   z80_req;
    z80_rsp_t   z80_rsp;
    delay_t     delay_sel_det;
    logic       i2c_sda_in;
    gpio_pins_t pins;
    logic       bus_fault;

    integer     seed;
    data_t      ram_model [RAM_WORDS];
    byte_t      z80_model [2**16];
    int         ram_idx [16];
    z80_addr_t  z80_adr [8];
    int         unused_idx [5] = '{2, 4, 5, 7, 15};   // GPIO holes and write-only registers

    soc_fabric_top i_soc_fabric_top (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .host_req      (host_req),
        .host_rsp      (host_rsp),
        .z80_req       (z80_req),
        .z80_rsp       (z80_rsp),
        .delay_sel_det (delay_sel_det),
        .i2c_sda_in    (i2c_sda_in),
        .pins          (pins),
        .bus_fault     (bus_fault)
    );

    initial clk_rv = 1'b0;
    always #5 clk_rv = ~clk_rv;

    // Error handling ----------------------------
    task automatic flag_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s at %0t ns", what, $time);
        $display("Verification failed");
        $fatal(1, "simulation stopped on timeout");
    endtask

    task automatic check_word(input string what, input data_t got, input data_t exp);
        assert (got === exp)
            else flag_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // Address helpers and byte merge
    function automatic addr_t gpio_addr(input int idx);
        return GPIO_BASE + 4 * idx;
    endfunction

    function automatic addr_t z80_addr(input z80_addr_t a);
        return Z80_BASE + {a, 2'b00};        // One Z80 byte per host word
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t wdat, input sel_t sel);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                res[8*b +: 8] = wdat[8*b +: 8];
        end
        return res;
    endfunction

    // Bus tasks ---------------------------------
    task automatic bus_cycle(input logic we, input addr_t adr, input data_t dat, input sel_t sel,
                             output data_t rdat, output logic got_ack, output logic got_err);
        int   cnt;
        logic done;
        @(posedge clk_rv);
        host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_rv);
            cnt++;
            done = host_rsp.ack || host_rsp.err;
            if (!done && cnt >= BUS_TIMEOUT)
                stop_on_timeout($sformatf("host response at %h", adr));
        end
        rdat    = host_rsp.dat;
        got_ack = host_rsp.ack;
        got_err = host_rsp.err;
        @(posedge clk_rv);
        host_req <= '0;                      // Strobe low for at least one cycle
    endtask

    task automatic wb_write(input addr_t adr, input data_t dat, input sel_t sel);
        data_t rdat;
        logic  got_ack;
        logic  got_err;
        bus_cycle(1'b1, adr, dat, sel, rdat, got_ack, got_err);
        assert (got_ack && !got_err)
            else flag_mismatch($sformatf("write to %h not acked", adr));
    endtask

    task automatic wb_read(input addr_t adr, output data_t rdat);
        logic got_ack;
        logic got_err;
        bus_cycle(1'b0, adr, '0, 4'hF, rdat, got_ack, got_err);
        assert (got_ack && !got_err)
            else flag_mismatch($sformatf("read from %h not acked", adr));
    endtask

    // A low expect_ready means the request must stay unserved
    task automatic z80_access(input logic we, input z80_addr_t adr, input byte_t dat,
                              input logic expect_ready, output byte_t rdat);
        int   cnt;
        logic seen;
        @(posedge clk_rv);
        z80_req <= '{mreq: 1'b1, we: we, adr: adr, dat: dat};
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < Z80_TIMEOUT) begin
            @(negedge clk_rv);
            cnt++;
            seen = z80_rsp.ready;
        end
        rdat = z80_rsp.dat;
        if (expect_ready && !seen)
            stop_on_timeout($sformatf("Z80 ready at %h", adr));
        assert (expect_ready || !seen)
            else flag_mismatch("Z80 request served while held in reset");
        @(posedge clk_rv);
        z80_req <= '0;
    endtask

    // Protocol checks ---------------------------
    assert property (@(posedge clk_rv) disable iff (!rst_rv) !(host_rsp.ack && host_rsp.err))
        else flag_mismatch("ack and err in the same cycle");
    assert property (@(posedge clk_rv) disable iff (!rst_rv) host_rsp.ack |=> !host_rsp.ack)
        else flag_mismatch("host ack longer than one cycle");
    assert property (@(posedge clk_rv) disable iff (!rst_rv) host_rsp.err |=> !host_rsp.err)
        else flag_mismatch("host err longer than one cycle");
    assert property (@(posedge clk_rv) disable iff (!rst_rv) z80_rsp.ready |=> !z80_rsp.ready)
        else flag_mismatch("Z80 ready longer than one cycle");
    assert property (@(posedge clk_rv) disable iff (!rst_rv) bus_fault |=> bus_fault)
        else flag_mismatch("bus_fault cleared without reset");

    initial begin
        data_t      rdat;
        data_t      wdat;
        sel_t       sel;
        byte_t      zdat;
        byte_t      zwr;
        logic       got_ack;
        logic       got_err;
        int         k;
        gpio_pins_t exp_pins;
        seed          = 24;
        rst_rv        <= 1'b0;
        host_req      <= '0;
        z80_req       <= '0;
        delay_sel_det <= DELAY_STRAP;
        i2c_sda_in    <= 1'b1;
        repeat (3) @(posedge clk_rv);
        rst_rv <= 1'b1;
        @(negedge clk_rv);

        // Reset state
        assert (!host_rsp.ack && !host_rsp.err && !z80_rsp.ready && !bus_fault)
            else flag_mismatch("responses not idle after reset");
        exp_pins = '{led_r: 1'b0, led_g: 1'b0, led_b: 1'b0, z80_rst: 1'b1, i2c_scl: 1'b1,
                     i2c_sda_oe: 1'b0, usb_rst_n: 1'b0, delay_sel: DELAY_STRAP};
        check_word("pins after reset", pins, exp_pins);

        // Internal RAM gets full words first so every byte is known
        for (int i = 0; i < 16; i++) begin
            ram_idx[i] = $random(seed) & (RAM_WORDS - 1);
            wdat       = $random(seed);
            wb_write(RAM_BASE + 4 * ram_idx[i], wdat, 4'hF);
            ram_model[ram_idx[i]] = wdat;
        end
        for (int i = 0; i < 32; i++) begin
            k    = $random(seed) & 15;
            wdat = $random(seed);
            sel  = $random(seed);
            wb_write(RAM_BASE + 4 * ram_idx[k], wdat, sel);
            ram_model[ram_idx[k]] = merge_bytes(ram_model[ram_idx[k]], wdat, sel);
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(RAM_BASE + 4 * ram_idx[i], rdat);
            check_word("RAM read", rdat, ram_model[ram_idx[i]]);
            wb_read(RAM_BASE + 4 * (ram_idx[i] + RAM_WORDS), rdat);   // One depth higher
            check_word("RAM echo read", rdat, ram_model[ram_idx[i]]);
        end

        // Z80 still in reset so no ready
        z80_access(1'b0, 16'h0040, 8'h00, 1'b0, zdat);

        // GPIO registers ----------------------------
        wb_write(gpio_addr(GPIO_DELAY), 32'h0000_000A, 4'hF);
        check_word("delay_sel pin", pins.delay_sel, 32'h0A);
        wb_read(gpio_addr(GPIO_DELAY), rdat);
        check_word("delay_sel read", rdat, 32'h0A);
        wb_write(gpio_addr(GPIO_LED), 32'h0000_0005, 4'h1);
        check_word("LED pins", {pins.led_b, pins.led_g, pins.led_r}, 32'h5);
        wb_read(gpio_addr(GPIO_LED), rdat);
        check_word("LED read", rdat, 32'h5);
        wb_write(gpio_addr(GPIO_Z80RST), 32'h0, 4'h1);
        check_word("z80_rst pin low", pins.z80_rst, 32'h0);
        wb_read(gpio_addr(GPIO_Z80RST), rdat);
        check_word("z80_rst read low", rdat, 32'h0);
        wb_write(gpio_addr(GPIO_Z80RST), 32'h1, 4'h1);
        check_word("z80_rst pin", pins.z80_rst, 32'h1);
        wb_read(gpio_addr(GPIO_Z80RST), rdat);
        check_word("z80_rst read", rdat, 32'h1);
        wb_write(gpio_addr(GPIO_SCL), 32'h0, 4'h1);
        check_word("SCL pin", pins.i2c_scl, 32'h0);
        wb_write(gpio_addr(GPIO_SDA), 32'h0, 4'h1);
        check_word("SDA driven low", pins.i2c_sda_oe, 32'h1);
        wb_write(gpio_addr(GPIO_SDA), 32'h1, 4'h1);
        check_word("SDA released", pins.i2c_sda_oe, 32'h0);
        wb_write(gpio_addr(GPIO_USBRST), 32'h1, 4'h1);
        check_word("USB reset pin", pins.usb_rst_n, 32'h1);
        @(posedge clk_rv);
        i2c_sda_in <= 1'b0;
        wb_read(gpio_addr(GPIO_SDA), rdat);
        check_word("SDA input low", rdat, 32'h0);
        @(posedge clk_rv);
        i2c_sda_in <= 1'b1;
        wb_read(gpio_addr(GPIO_SDA), rdat);
        check_word("SDA input high", rdat, 32'h1);
        for (int i = 0; i < 5; i++) begin
            wb_read(gpio_addr(unused_idx[i]), rdat);
            check_word($sformatf("GPIO index %0d read", unused_idx[i]), rdat, 32'h0);
        end

        // Unmapped address
        assert (!bus_fault) else flag_mismatch("bus_fault set before any unmapped access");
        bus_cycle(1'b0, 32'h0400_0000, '0, 4'hF, rdat, got_ack, got_err);
        assert (got_err && !got_ack) else flag_mismatch("unmapped access not answered by err");
        repeat (4) @(negedge clk_rv);
        assert (bus_fault) else flag_mismatch("bus_fault not sticky");

        // Z80 RAM window ----------------------------
        for (int i = 0; i < 8; i++) begin
            z80_adr[i] = {12'($random(seed)), 4'(i)};   // Distinct addresses
            wdat       = $random(seed);
            wb_write(z80_addr(z80_adr[i]), wdat, 4'hF);
            z80_model[z80_adr[i]] = wdat[7:0];
        end
        wb_write(z80_addr(z80_adr[0]), 32'h0000_00FF, 4'hE);   // No low lane so nothing is stored
        for (int i = 0; i < 8; i++) begin
            wb_read(z80_addr(z80_adr[i]), rdat);
            check_word("Z80 window host read", rdat, {24'd0, z80_model[z80_adr[i]]});
        end
        wb_write(gpio_addr(GPIO_Z80RST), 32'h0, 4'h1);
        check_word("z80_rst released", pins.z80_rst, 32'h0);
        z80_access(1'b0, z80_adr[1], 8'h00, 1'b1, zdat);
        check_word("Z80 read of host data", zdat, z80_model[z80_adr[1]]);
        zwr = $random(seed);
        z80_access(1'b1, z80_adr[2], zwr, 1'b1, zdat);
        z80_model[z80_adr[2]] = zwr;
        wb_read(z80_addr(z80_adr[2]), rdat);
        check_word("host read of Z80 data", rdat, {24'd0, z80_model[z80_adr[2]]});

        // Both ports at once
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    z80_access(1'b0, z80_adr[i], 8'h00, 1'b1, zdat);
                    check_word("Z80 read under host traffic", zdat, z80_model[z80_adr[i]]);
                end
            end
            begin
                wdat = $random(seed);
                wb_write(z80_addr(z80_adr[5]), wdat, 4'h1);
                z80_model[z80_adr[5]] = wdat[7:0];
                wb_read(z80_addr(z80_adr[6]), rdat);
                check_word("host read under Z80 traffic", rdat, {24'd0, z80_model[z80_adr[6]]});
            end
        join
        fork
            z80_access(1'b1, z80_adr[7], 8'h5A, 1'b1, zdat);
            wb_read(z80_addr(z80_adr[5]), rdat);
        join
        z80_model[z80_adr[7]] = 8'h5A;
        check_word("host read beside Z80 write", rdat, {24'd0, z80_model[z80_adr[5]]});
        wb_read(z80_addr(z80_adr[7]), rdat);
        check_word("Z80 write seen by host", rdat, {24'd0, z80_model[z80_adr[7]]});

        $display("Verification passed");
        $finish;
    end

endmodule
